/* build.f */
source/bus_pkg.sv
source/bus_master.sv
source/bus_slave.sv
source/bus_arbiter.sv
source/bus_interconnect.sv
source/serial_bus_top.sv
verification/serial_bus_tb.sv

/* verification/bus_tests.txt */
# per master, master 0 then master 1: start op slave addr wdata expect (all hex)
# op 1 writes wdata, op 0 reads and compares rdata_out with expect
1 1 0 010 a5c3 0000   0 0 0 000 0000 0000
1 0 0 010 0000 a5c3   0 0 0 000 0000 0000
0 0 0 000 0000 0000   1 1 0 234 1f2e 0000
1 0 0 234 0000 1f2e   0 0 0 000 0000 0000
1 1 0 055 beef 0000   1 1 1 066 cafe 0000
1 0 0 055 0000 beef   1 0 1 066 0000 cafe
1 1 0 3ff 1111 0000   1 1 0 3ff 2222 0000
1 0 0 3ff 0000 2222   0 0 0 000 0000 0000
0 0 0 000 0000 0000   1 1 1 8a5 5a5a 0000
1 0 1 0a5 0000 5a5a   0 0 0 000 0000 0000
0 0 0 000 0000 0000   1 0 1 8a5 0000 5a5a
1 1 1 7ff 0f0f 0000   1 1 0 fff f0f0 0000
1 0 0 fff 0000 f0f0   1 0 1 fff 0000 0f0f
1 1 1 123 0001 0000   1 1 1 124 8000 0000
1 0 1 124 0000 8000   1 0 1 123 0000 0001
0 0 0 000 0000 0000   1 1 0 abc ffff 0000
1 0 1 123 0000 0001   1 0 0 abc 0000 ffff

/* verification/serial_bus_tb.sv */
`timescale 1ns/1ns

module serial_bus_tb import bus_pkg::*; ();

    typedef struct packed {
        logic      start;
        bus_op_e   op;
        slave_id_t slave;
        addr_t     addr;
        data_t     wdata;
        data_t     expect_rd;  // only meaningful for reads
    } cmd_t;

    logic      clk;
    logic      rstN;
    logic      cmd_start [NUM_MASTERS];
    bus_op_e   cmd_op    [NUM_MASTERS];
    slave_id_t cmd_slave [NUM_MASTERS];
    addr_t     cmd_addr  [NUM_MASTERS];
    data_t     cmd_wdata [NUM_MASTERS];
    logic      done      [NUM_MASTERS];
    data_t     rdata_out [NUM_MASTERS];

    cmd_t   cmd_q [$];      // two entries per test line, master 0 first
    data_t  ref_mem [int];  // expected contents of both slaves
    int     num_lines   = 0;
    int     cycle_cnt   = 0;
    int     cycle_limit = 0;
    integer seed        = 56;

    serial_bus_top dut_i (
        .clk, .rstN,
        .cmd_start, .cmd_op, .cmd_slave, .cmd_addr, .cmd_wdata,
        .done, .rdata_out
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: no progress after %0d clock cycles", cycle_cnt);
            abort_run();
        end
    end

    // slave 1 decodes only its low address bits, slave 0 words sit below it
    function automatic int mem_key(input slave_id_t slave, input addr_t addr);
        if (slave == 1'b1) begin
            return SLAVE0_DEPTH + (int'(addr) % SLAVE1_DEPTH);
        end
        return int'(addr);
    endfunction

    task automatic push_cmd(input logic start, input logic op, input logic slave,
                            input logic [11:0] addr, input logic [15:0] wdata,
                            input logic [15:0] exp_rd);
        cmd_q.push_back('{start, bus_op_e'(op), slave, addr, wdata, exp_rd});
        if (start && op) begin
            ref_mem[mem_key(slave, addr)] = wdata;  // same-line writes land in master order
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [15:0] f [12];
        fd = $fopen("verification/bus_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file verification/bus_tests.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n == 0 || line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
            if (n <= 0) continue;  // blank line
            if (n != 12) begin
                $display("A test line does not hold twelve fields: %s", line);
                abort_run();
            end
            push_cmd(f[0][0], f[1][0], f[2][0], f[3][11:0], f[4], f[5]);
            push_cmd(f[6][0], f[7][0], f[8][0], f[9][11:0], f[10], f[11]);
            num_lines++;
        end
        $fclose(fd);
    endtask

    // one master writes a random word, the other one reads it back
    task automatic add_random_lines(input int count);
        int          r;
        int          wr_m;
        logic        slave;
        logic [11:0] addr;
        logic [15:0] data;
        logic [15:0] exp_rd;
        for (int i = 0; i < count; i++) begin
            wr_m  = i % NUM_MASTERS;
            r     = $random(seed);
            slave = r[12];
            addr  = r[11:0];
            r     = $random(seed);
            data  = r[15:0];
            for (int m = 0; m < NUM_MASTERS; m++) begin
                push_cmd(m == wr_m, 1'b1, slave, addr, data, 16'h0000);
            end
            exp_rd = ref_mem[mem_key(slave, addr)];
            for (int m = 0; m < NUM_MASTERS; m++) begin
                push_cmd(m != wr_m, 1'b0, slave, addr, 16'h0000, exp_rd);
            end
            num_lines += 2;
        end
    endtask

    task automatic check_reset_state();
        repeat (5) begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                check($sformatf("done[%0d]", m), done[m], 0);
                check($sformatf("rdata_out[%0d]", m), rdata_out[m], 0);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_line(input int idx);
        cmd_t c       [NUM_MASTERS];
        logic pending [NUM_MASTERS];
        for (int m = 0; m < NUM_MASTERS; m++) begin
            c[m]         = cmd_q[NUM_MASTERS * idx + m];
            pending[m]   = c[m].start;
            cmd_start[m] = c[m].start;
            cmd_op[m]    = c[m].op;
            cmd_slave[m] = c[m].slave;
            cmd_addr[m]  = c[m].addr;
            cmd_wdata[m] = c[m].wdata;
        end
        @(posedge clk);
        #1;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            cmd_start[m] = 1'b0;
        end
        while (pending[0] || pending[1]) begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (pending[m] && done[m]) begin
                    pending[m] = 1'b0;
                    if (c[m].op == op_read) begin
                        check($sformatf("rdata_out[%0d]", m), rdata_out[m], c[m].expect_rd);
                    end
                end else if (!pending[m]) begin
                    check($sformatf("done[%0d]", m), done[m], 0);  // no stray pulse
                end
            end
            if (pending[0] || pending[1]) begin
                @(posedge clk);
                #1;
            end
        end
        @(posedge clk);  // finish state, master is back in idle after this edge
        #1;
    endtask

    initial begin
        rstN = 1'b0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            cmd_start[m] = 1'b0;
            cmd_op[m]    = op_read;
            cmd_slave[m] = '0;
            cmd_addr[m]  = '0;
            cmd_wdata[m] = '0;
        end
        load_tests();
        if (num_lines == 0) begin
            $display("No test lines were found in the test file");
            abort_run();
        end
        add_random_lines(4);
        cycle_limit = 200 * num_lines;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        check_reset_state();
        for (int i = 0; i < num_lines; i++) begin
            run_line(i);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* source/serial_bus_top.sv */
`timescale 1ns/1ns

module serial_bus_top import bus_pkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      cmd_start [NUM_MASTERS],
    input  bus_op_e   cmd_op    [NUM_MASTERS],
    input  slave_id_t cmd_slave [NUM_MASTERS],
    input  addr_t     cmd_addr  [NUM_MASTERS],
    input  data_t     cmd_wdata [NUM_MASTERS],
    output logic      done      [NUM_MASTERS],
    output data_t     rdata_out [NUM_MASTERS]
);

    // master side
    logic       bus_req   [NUM_MASTERS];
    slave_id_t  req_slave [NUM_MASTERS];
    logic       bus_grant [NUM_MASTERS];
    logic       m_ctrl    [NUM_MASTERS];
    logic       m_wdata   [NUM_MASTERS];
    logic       m_wvalid  [NUM_MASTERS];
    logic       m_rdata   [NUM_MASTERS];
    logic       m_ready   [NUM_MASTERS];

    // slave side
    logic       s_ctrl    [NUM_SLAVES];
    logic       s_wdata   [NUM_SLAVES];
    logic       s_wvalid  [NUM_SLAVES];
    logic       s_rdata   [NUM_SLAVES];
    logic       s_ready   [NUM_SLAVES];

    logic       bus_busy;
    master_id_t bus_owner;
    slave_id_t  bus_target;

    genvar m;
    for (m = 0; m < NUM_MASTERS; m++) begin : g_master
        bus_master master_i (
            .clk, .rstN,
            .cmd_start (cmd_start[m]),
            .cmd_op    (cmd_op[m]),
            .cmd_slave (cmd_slave[m]),
            .cmd_addr  (cmd_addr[m]),
            .cmd_wdata (cmd_wdata[m]),
            .bus_grant (bus_grant[m]),
            .rdata     (m_rdata[m]),
            .ready     (m_ready[m]),
            .done      (done[m]),
            .rdata_out (rdata_out[m]),
            .bus_req   (bus_req[m]),
            .req_slave (req_slave[m]),
            .ctrl      (m_ctrl[m]),
            .wdata     (m_wdata[m]),
            .wvalid    (m_wvalid[m])
        );
    end

    bus_slave #(.DEPTH(SLAVE0_DEPTH)) slave0_i (
        .clk, .rstN,
        .ctrl(s_ctrl[0]), .wdata(s_wdata[0]), .wvalid(s_wvalid[0]),
        .rdata(s_rdata[0]), .ready(s_ready[0])
    );

    bus_slave #(.DEPTH(SLAVE1_DEPTH)) slave1_i (
        .clk, .rstN,
        .ctrl(s_ctrl[1]), .wdata(s_wdata[1]), .wvalid(s_wvalid[1]),
        .rdata(s_rdata[1]), .ready(s_ready[1])
    );

    bus_arbiter arbiter_i (
        .clk, .rstN,
        .bus_req, .req_slave, .bus_grant,
        .bus_busy, .bus_owner, .bus_target
    );

    bus_interconnect interconnect_i (
        .bus_busy, .bus_owner, .bus_target,
        .m_ctrl, .m_wdata, .m_wvalid,
        .s_rdata, .s_ready,
        .s_ctrl, .s_wdata, .s_wvalid,
        .m_rdata, .m_ready
    );

endmodule

/* source/bus_interconnect.sv */
`timescale 1ns/1ns

module bus_interconnect import bus_pkg::*; (
    input  logic       bus_busy,
    input  master_id_t bus_owner,
    input  slave_id_t  bus_target,
    input  logic       m_ctrl   [NUM_MASTERS],
    input  logic       m_wdata  [NUM_MASTERS],
    input  logic       m_wvalid [NUM_MASTERS],
    input  logic       s_rdata  [NUM_SLAVES],
    input  logic       s_ready  [NUM_SLAVES],
    output logic       s_ctrl   [NUM_SLAVES],
    output logic       s_wdata  [NUM_SLAVES],
    output logic       s_wvalid [NUM_SLAVES],
    output logic       m_rdata  [NUM_MASTERS],
    output logic       m_ready  [NUM_MASTERS]
);

    logic fwd_sel [NUM_SLAVES];   // slave is the current target
    logic ret_sel [NUM_MASTERS];  // master is the current owner

    // forward lines, owner to target, zeros elsewhere
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            fwd_sel[s]  = bus_busy && (bus_target == slave_id_t'(s));
            s_ctrl[s]   = fwd_sel[s] && m_ctrl[bus_owner];
            s_wdata[s]  = fwd_sel[s] && m_wdata[bus_owner];
            s_wvalid[s] = fwd_sel[s] && m_wvalid[bus_owner];
        end
    end

    // return lines, target back to owner only
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            ret_sel[m] = bus_busy && (bus_owner == master_id_t'(m));
            m_rdata[m] = ret_sel[m] && s_rdata[bus_target];
            m_ready[m] = ret_sel[m] && s_ready[bus_target];  // others see not ready
        end
    end

endmodule

/* source/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter import bus_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       bus_req   [NUM_MASTERS],
    input  slave_id_t  req_slave [NUM_MASTERS],
    output logic       bus_grant [NUM_MASTERS],
    output logic       bus_busy,
    output master_id_t bus_owner,
    output slave_id_t  bus_target
);

    logic       any_req;
    master_id_t next_owner;  // lowest numbered requester

    always_comb begin
        any_req    = 1'b0;
        next_owner = '0;
        for (int m = NUM_MASTERS - 1; m >= 0; m--) begin
            if (bus_req[m]) begin
                any_req    = 1'b1;
                next_owner = master_id_t'(m);
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bus_busy   <= 1'b0;
            bus_owner  <= '0;
            bus_target <= '0;
        end else if (!bus_busy) begin
            if (any_req) begin
                bus_busy   <= 1'b1;
                bus_owner  <= next_owner;
                bus_target <= req_slave[next_owner];
            end
        end else if (!bus_req[bus_owner]) begin
            bus_busy <= 1'b0;  // owner done, no preemption before this
        end
    end

    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            bus_grant[m] = bus_busy && (bus_owner == master_id_t'(m));
        end
    end

    // owner and route stay put while the owner still requests
    owner_holds_bus: assert property (@(posedge clk) disable iff (!rstN)
        (bus_busy && bus_req[bus_owner])
            |=> (bus_busy && $stable(bus_owner) && $stable(bus_target)));

endmodule

/* source/bus_slave.sv */
`timescale 1ns/1ns

module bus_slave import bus_pkg::*; #(
    parameter  int DEPTH   = SLAVE0_DEPTH,
    localparam int LADDR_W = $clog2(DEPTH)
) (
    input  logic clk,
    input  logic rstN,
    input  logic ctrl,
    input  logic wdata,
    input  logic wvalid,
    output logic rdata,
    output logic ready
);

    typedef enum logic [2:0] {
        idle,
        get_ctrl,
        get_data,
        read_mem,
        send_data
    } state_e;

    typedef logic [$clog2(ADDR_W + DATA_W)-1:0] cnt_t;

    state_e             state;
    cnt_t               bit_cnt;
    logic [ADDR_W-1:0]  ctrl_sr;  // frame bits collected so far
    logic [ADDR_W:0]    frame;    // opcode and address, with the bit on ctrl now
    logic [LADDR_W-1:0] addr_q;   // upper address bits dropped, so slave 1 wraps
    data_t              wr_sr;
    logic [DATA_W:0]    rd_sr;    // start bit in front of the read word
    data_t              mem [DEPTH];

    assign frame = {ctrl_sr, ctrl};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (ctrl) begin  // start bit
                        bit_cnt <= '0;
                        state   <= get_ctrl;
                    end
                end
                get_ctrl: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == cnt_t'(ADDR_W)) begin
                        bit_cnt <= '0;
                        if (bus_op_e'(frame[ADDR_W]) == op_write) begin
                            state <= get_data;
                        end else begin
                            state <= read_mem;
                        end
                    end
                end
                get_data: begin
                    if (wvalid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == cnt_t'(DATA_W - 1)) begin
                            state <= idle;
                        end
                    end
                end
                read_mem: begin
                    state <= send_data;
                end
                send_data: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == cnt_t'(DATA_W)) begin  // start bit plus DATA_W bits
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            get_ctrl: begin
                ctrl_sr <= frame[ADDR_W-1:0];
                addr_q  <= frame[LADDR_W-1:0];
            end
            get_data: begin
                if (wvalid) begin
                    wr_sr <= {wr_sr[DATA_W-2:0], wdata};
                    if (bit_cnt == cnt_t'(DATA_W - 1)) begin
                        mem[addr_q] <= {wr_sr[DATA_W-2:0], wdata};
                    end
                end
            end
            read_mem:  rd_sr <= {1'b1, mem[addr_q]};
            send_data: rd_sr <= rd_sr << 1;
            default: ;
        endcase
    end

    assign ready = (state == idle);
    assign rdata = (state == send_data) && rd_sr[DATA_W];

    // once busy, a high ctrl can only be part of the frame being collected
    ctrl_only_in_frame: assert property (@(posedge clk) disable iff (!rstN)
        (ctrl && !ready) |-> (state == get_ctrl));

endmodule

/* source/bus_master.sv */
`timescale 1ns/1ns

module bus_master import bus_pkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      cmd_start,
    input  bus_op_e   cmd_op,
    input  slave_id_t cmd_slave,
    input  addr_t     cmd_addr,
    input  data_t     cmd_wdata,
    input  logic      bus_grant,
    input  logic      rdata,
    input  logic      ready,
    output logic      done,
    output data_t     rdata_out,
    output logic      bus_req,
    output slave_id_t req_slave,
    output logic      ctrl,
    output logic      wdata,
    output logic      wvalid
);

    typedef enum logic [2:0] {
        idle,
        request,
        wait_ready,
        send_ctrl,
        send_data,
        recv_data,
        finish
    } state_e;

    typedef logic [$clog2(ADDR_W + DATA_W)-1:0] cnt_t;

    state_e            state;
    cnt_t              bit_cnt;
    logic              got_start;  // read start bit seen on rdata
    bus_op_e           op_q;
    addr_t             addr_q;
    logic [ADDR_W+1:0] ctrl_sr;    // start bit, opcode, address
    data_t             data_sr;    // write word out or read word in

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= idle;
            bit_cnt   <= '0;
            got_start <= 1'b0;
            rdata_out <= '0;
        end else begin
            case (state)
                idle: begin
                    if (cmd_start) begin
                        state <= request;
                    end
                end
                request: begin
                    if (bus_grant) begin
                        state <= wait_ready;
                    end
                end
                wait_ready: begin
                    bit_cnt   <= '0;
                    got_start <= 1'b0;
                    if (ready) begin
                        state <= send_ctrl;
                    end
                end
                send_ctrl: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == cnt_t'(ADDR_W + 1)) begin  // last address bit
                        bit_cnt <= '0;
                        state   <= (op_q == op_write) ? send_data : recv_data;
                    end
                end
                send_data: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == cnt_t'(DATA_W - 1)) begin
                        state <= finish;
                    end
                end
                recv_data: begin
                    if (!got_start) begin
                        got_start <= rdata;  // slave is still fetching the word
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == cnt_t'(DATA_W - 1)) begin
                            rdata_out <= {data_sr[DATA_W-2:0], rdata};
                            state     <= finish;
                        end
                    end
                end
                finish: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (cmd_start) begin
                    op_q      <= cmd_op;
                    req_slave <= cmd_slave;
                    addr_q    <= cmd_addr;
                    data_sr   <= cmd_wdata;
                end
            end
            wait_ready: ctrl_sr <= {1'b1, op_q, addr_q};
            send_ctrl:  ctrl_sr <= ctrl_sr << 1;
            send_data:  data_sr <= data_sr << 1;
            recv_data: begin
                if (got_start) begin
                    data_sr <= {data_sr[DATA_W-2:0], rdata};
                end
            end
            default: ;
        endcase
    end

    // request is dropped in the done cycle so the arbiter frees the bus next
    assign bus_req = state inside {request, wait_ready, send_ctrl, send_data, recv_data};
    assign done    = (state == finish);
    assign ctrl    = (state == send_ctrl) && ctrl_sr[ADDR_W+1];  // msb first
    assign wvalid  = (state == send_data);
    assign wdata   = wvalid && data_sr[DATA_W-1];

    // during the data phase the bus is ours and the slave is busy collecting
    wvalid_in_data_phase: assert property (@(posedge clk) disable iff (!rstN)
        wvalid |-> (state == send_data) && bus_grant && !ready);

endmodule

/* source/bus_pkg.sv */
package bus_pkg;

    localparam int NUM_MASTERS  = 2;
    localparam int NUM_SLAVES   = 2;
    localparam int DATA_W       = 16;
    localparam int SLAVE0_DEPTH = 4096;
    localparam int SLAVE1_DEPTH = 2048;
    localparam int ADDR_W       = $clog2(SLAVE0_DEPTH);  // covers the deepest slave

    typedef logic [DATA_W-1:0]              data_t;
    typedef logic [ADDR_W-1:0]              addr_t;
    typedef logic [$clog2(NUM_SLAVES)-1:0]  slave_id_t;
    typedef logic [$clog2(NUM_MASTERS)-1:0] master_id_t;

    // opcode bit as it travels in the control frame
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } bus_op_e;

endpackage
